//--- hwcnn_pkg.sv
package hwcnn_pkg;

////////////////////////////////////////////////////////////////////////////
// sizes

	localparam int LANES      = 9;              // values per beat, taps per kernel
	localparam int VAL_W      = 8;              // one signed weight or feature value
	localparam int BEAT_W     = LANES * VAL_W;  // memory data width
	localparam int BIAS_W     = 20;
	localparam int ACC_W      = 24;             // accumulator and result
	localparam int SHIFT_W    = 5;
	localparam int BUF_ADDR_W = 8;
	localparam int BUF_DEPTH  = 1 << BUF_ADDR_W;
	localparam int NUM_TGT    = 3;              // weight, bias and feature buffers
	localparam int DDR_ADDR_W = 29;             // beat addresses
	localparam int CMD_W      = 3;
	localparam int CNT_W      = 8;              // a count of 0 means 256
	localparam int INST_W     = 64;
	localparam int PAYLOAD_W  = INST_W - 2;     // everything below the opcode

	localparam logic [CMD_W-1:0] CMD_READ = 3'd1;

////////////////////////////////////////////////////////////////////////////
// instruction format

	typedef enum logic [1:0] {
		OP_NOP  = 2'd0,
		OP_LOAD = 2'd1,
		OP_CONV = 2'd2
	} opcode_e;

	typedef enum logic [1:0] {
		TGT_WEIGHT  = 2'd0,
		TGT_BIAS    = 2'd1,
		TGT_FEATURE = 2'd2
	} target_e;

	typedef struct packed {
		target_e                 target;
		logic [DDR_ADDR_W-1:0]   ddr_addr;
		logic [BUF_ADDR_W-1:0]   buf_addr;
		logic [CNT_W-1:0]        beats;
	} load_cmd_t;

	typedef struct packed {
		logic [BUF_ADDR_W-1:0]   weight_addr;
		logic [BUF_ADDR_W-1:0]   bias_addr;
		logic [BUF_ADDR_W-1:0]   feat_addr;  // first window
		logic [CNT_W-1:0]        count;      // number of windows
		logic [SHIFT_W-1:0]      shift;
	} conv_cmd_t;

	// the opcode picks which of the two readings is meant
	typedef union packed {
		struct packed {
			logic [PAYLOAD_W-$bits(load_cmd_t)-1:0] pad;
			load_cmd_t                              cmd;
		} load;
		struct packed {
			logic [PAYLOAD_W-$bits(conv_cmd_t)-1:0] pad;
			conv_cmd_t                              cmd;
		} conv;
	} inst_payload_u;

	typedef struct packed {
		opcode_e       opcode;
		inst_payload_u payload;
	} inst_t;

	// datapath bundles
	typedef struct packed {
		logic                  en;
		target_e               target;
		logic [BUF_ADDR_W-1:0] addr;
		logic [BEAT_W-1:0]     data;
	} buf_wr_t;

	typedef struct packed {
		logic [BUF_ADDR_W-1:0] weight_addr;
		logic [BUF_ADDR_W-1:0] bias_addr;
		logic [BUF_ADDR_W-1:0] feat_addr;
	} conv_rd_t;

	typedef struct packed {
		logic [BEAT_W-1:0]        weight;   // 3x3 kernel, lane 0 in the low byte
		logic [BEAT_W-1:0]        feature;  // 3x3 window
		logic signed [BIAS_W-1:0] bias;
		logic [SHIFT_W-1:0]       shift;
	} pe_operands_t;

endpackage

//--- inst_ctrl.sv
module inst_ctrl import hwcnn_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [INST_W-1:0] instruct,
	input  logic              inst_empty,
	output logic              inst_req,
	output logic              load_start,
	output load_cmd_t         load_cmd,
	input  logic              load_done,
	output logic              conv_start,
	output conv_cmd_t         conv_cmd,
	input  logic              conv_done
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_FETCH,
		S_DECODE,
		S_WAIT
	} state_e;

	state_e state;
	inst_t  inst;
	logic   wait_load;  // selects which done pulse ends the wait

	assign inst = inst_t'(instruct);

	// fetch / decode FSM
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= S_IDLE;
			inst_req   <= 1'b0;
			load_start <= 1'b0;
			conv_start <= 1'b0;
			wait_load  <= 1'b0;
		end else begin
			inst_req   <= 1'b0;
			load_start <= 1'b0;
			conv_start <= 1'b0;
			case (state)
				S_IDLE: begin
					if (!inst_empty) begin
						inst_req <= 1'b1;  // one pop
						state    <= S_FETCH;
					end
				end
				S_FETCH: state <= S_DECODE;  // fifo output moves on this edge
				S_DECODE: begin
					case (inst.opcode)
						OP_LOAD: begin
							load_start <= 1'b1;
							wait_load  <= 1'b1;
							state      <= S_WAIT;
						end
						OP_CONV: begin
							conv_start <= 1'b1;
							wait_load  <= 1'b0;
							state      <= S_WAIT;
						end
						default: state <= S_IDLE;  // nop is dropped
					endcase
				end
				S_WAIT: begin
					if (wait_load ? load_done : conv_done)
						state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// command registers, loaded with the start pulse
	always_ff @(posedge clk) begin
		if (state == S_DECODE && inst.opcode == OP_LOAD)
			load_cmd <= inst.payload.load.cmd;
		if (state == S_DECODE && inst.opcode == OP_CONV)
			conv_cmd <= inst.payload.conv.cmd;
	end

endmodule

//--- ddr_reader.sv
module ddr_reader import hwcnn_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  load_start,
	input  load_cmd_t             load_cmd,
	output logic                  load_done,
	input  logic                  init_calib_complete,
	input  logic                  app_rdy,
	input  logic                  app_rd_data_valid,
	input  logic [BEAT_W-1:0]     app_rd_data,
	output logic [CMD_W-1:0]      app_cmd,
	output logic [DDR_ADDR_W-1:0] app_addr,
	output logic                  app_en,
	output buf_wr_t               buf_wr
);

	target_e               target_r;
	logic [BUF_ADDR_W-1:0] buf_base;
	logic [CNT_W-1:0]      last_idx;  // beats - 1, a count of 0 wraps to 255
	logic [CNT_W-1:0]      cmd_cnt;   // commands accepted so far
	logic [CNT_W-1:0]      ret_cnt;   // beats returned so far
	logic                  cmd_busy;
	logic                  ret_busy;
	logic                  cmd_accept;
	logic                  beat_in;

	assign app_cmd    = CMD_READ;  // read only
	assign cmd_accept = app_en && app_rdy;
	assign beat_in    = app_rd_data_valid && ret_busy;

////////////////////////////////////////////////////////////////////////////
// command and return counters

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			app_en    <= 1'b0;
			cmd_busy  <= 1'b0;
			ret_busy  <= 1'b0;
			load_done <= 1'b0;
			cmd_cnt   <= '0;
			ret_cnt   <= '0;
		end else begin
			load_done <= 1'b0;
			if (load_start) begin
				cmd_busy <= 1'b1;
				ret_busy <= 1'b1;
				cmd_cnt  <= '0;
				ret_cnt  <= '0;
			end else begin
				// app_en stays up until the controller takes the command
				if (cmd_accept) begin
					cmd_cnt <= cmd_cnt + 1'b1;
					if (cmd_cnt == last_idx) begin
						app_en   <= 1'b0;
						cmd_busy <= 1'b0;
					end
				end else if (cmd_busy && init_calib_complete) begin
					app_en <= 1'b1;
				end
				if (beat_in) begin
					ret_cnt <= ret_cnt + 1'b1;
					if (ret_cnt == last_idx) begin
						ret_busy  <= 1'b0;
						load_done <= 1'b1;  // the cycle after the last write
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load_start) begin
			target_r <= load_cmd.target;
			buf_base <= load_cmd.buf_addr;
			last_idx <= load_cmd.beats - 1'b1;
			app_addr <= load_cmd.ddr_addr;
		end else if (cmd_accept) begin
			app_addr <= app_addr + 1'b1;  // next beat
		end
	end

	// returned beats go straight into the buffer
	always_comb begin
		buf_wr.en     = beat_in;
		buf_wr.target = target_r;
		buf_wr.addr   = buf_base + ret_cnt;
		buf_wr.data   = app_rd_data;
	end

endmodule

//--- local_buffers.sv
module local_buffers import hwcnn_pkg::*; (
	input  logic               clk,
	input  buf_wr_t            buf_wr,
	input  logic               rd_en,
	input  conv_rd_t           rd,
	input  logic [SHIFT_W-1:0] shift,
	output logic               pe_in_valid,
	output pe_operands_t       pe_in
);

	logic [BUF_ADDR_W-1:0] rd_addr [NUM_TGT];
	logic [BEAT_W-1:0]     rd_q    [NUM_TGT];
	logic [SHIFT_W-1:0]    shift_q;

	// read address per buffer, indexed by target code
	assign rd_addr[TGT_WEIGHT]  = rd.weight_addr;
	assign rd_addr[TGT_BIAS]    = rd.bias_addr;
	assign rd_addr[TGT_FEATURE] = rd.feat_addr;

	// one simple dual port RAM per target
	for (genvar t = 0; t < NUM_TGT; t++) begin : g_ram
		logic [BEAT_W-1:0] mem [BUF_DEPTH];

		always_ff @(posedge clk) begin
			if (buf_wr.en && buf_wr.target == target_e'(t))
				mem[buf_wr.addr] <= buf_wr.data;
			if (rd_en)
				rd_q[t] <= mem[rd_addr[t]];  // registered read
		end
	end

	// valid and shift follow the one cycle read latency
	always_ff @(posedge clk) begin
		pe_in_valid <= rd_en;
		shift_q     <= shift;
	end

	always_comb begin
		pe_in.weight  = rd_q[TGT_WEIGHT];
		pe_in.feature = rd_q[TGT_FEATURE];
		pe_in.bias    = rd_q[TGT_BIAS][BIAS_W-1:0];  // low bits of the bias beat
		pe_in.shift   = shift_q;
	end

endmodule

//--- conv_seq.sv
module conv_seq import hwcnn_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               conv_start,
	input  conv_cmd_t          conv_cmd,
	output logic               rd_en,
	output conv_rd_t           rd,
	output logic [SHIFT_W-1:0] shift,
	input  logic               result_valid,
	output logic               conv_done
);

	logic [CNT_W-1:0] issue_left;  // reads still to go after this one
	logic [CNT_W-1:0] last_idx;
	logic [CNT_W-1:0] res_cnt;
	logic             busy;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_en      <= 1'b0;
			busy       <= 1'b0;
			conv_done  <= 1'b0;
			issue_left <= '0;
			res_cnt    <= '0;
		end else begin
			conv_done <= 1'b0;
			if (conv_start) begin
				rd_en      <= 1'b1;
				busy       <= 1'b1;
				issue_left <= conv_cmd.count - 1'b1;
				res_cnt    <= '0;
			end else begin
				if (rd_en) begin
					if (issue_left == '0)
						rd_en <= 1'b0;
					else
						issue_left <= issue_left - 1'b1;
				end
				// done waits for the pipeline to drain
				if (result_valid && busy) begin
					res_cnt <= res_cnt + 1'b1;
					if (res_cnt == last_idx) begin
						busy      <= 1'b0;
						conv_done <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (conv_start) begin
			rd.weight_addr <= conv_cmd.weight_addr;
			rd.bias_addr   <= conv_cmd.bias_addr;
			rd.feat_addr   <= conv_cmd.feat_addr;
			shift          <= conv_cmd.shift;  // held for the whole run
			last_idx       <= conv_cmd.count - 1'b1;
		end else if (rd_en) begin
			rd.feat_addr <= rd.feat_addr + 1'b1;  // one window per cycle
		end
	end

endmodule

//--- pe_core.sv
module pe_core import hwcnn_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  pe_operands_t     pe_in,
	output logic             result_valid,
	output logic [ACC_W-1:0] result
);

	logic signed [2*VAL_W-1:0] prod [LANES];  // stage 1
	logic signed [BIAS_W-1:0]  bias_s1;
	logic [SHIFT_W-1:0]        shift_s1;
	logic signed [ACC_W-1:0]   sum_c;
	logic signed [ACC_W-1:0]   sum_s2;        // stage 2
	logic [SHIFT_W-1:0]        shift_s2;
	logic                      v1;
	logic                      v2;

////////////////////////////////////////////////////////////////////////////
// valid pipe, one bit per stage

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			v1           <= 1'b0;
			v2           <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			v1           <= in_valid;
			v2           <= v1;
			result_valid <= v2;
		end
	end

	// stage 1: nine signed products
	always_ff @(posedge clk) begin
		for (int i = 0; i < LANES; i++) begin
			prod[i] <= $signed(pe_in.weight[i*VAL_W +: VAL_W])
				* $signed(pe_in.feature[i*VAL_W +: VAL_W]);
		end
		bias_s1  <= pe_in.bias;
		shift_s1 <= pe_in.shift;
	end

	// adder tree plus sign extended bias
	always_comb begin
		sum_c = bias_s1;
		for (int i = 0; i < LANES; i++)
			sum_c = sum_c + prod[i];
	end

	// stage 2 and stage 3
	always_ff @(posedge clk) begin
		sum_s2   <= sum_c;
		shift_s2 <= shift_s1;
		result   <= sum_s2 >>> shift_s2;  // arithmetic shift keeps the sign
	end

endmodule

//--- hwcnn_top.sv
module hwcnn_top import hwcnn_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,

	input  logic [INST_W-1:0]     instruct,
	input  logic                  inst_empty,
	output logic                  inst_req,

	// memory controller user interface, read side only
	input  logic                  init_calib_complete,
	input  logic                  app_rdy,
	input  logic                  app_rd_data_valid,
	input  logic [BEAT_W-1:0]     app_rd_data,
	output logic [CMD_W-1:0]      app_cmd,
	output logic [DDR_ADDR_W-1:0] app_addr,
	output logic                  app_en,

	output logic                  result_valid,
	output logic [ACC_W-1:0]      result
);

	logic               load_start;
	load_cmd_t          load_cmd;
	logic               load_done;
	logic               conv_start;
	conv_cmd_t          conv_cmd;
	logic               conv_done;
	buf_wr_t            buf_wr;
	logic               rd_en;
	conv_rd_t           rd;
	logic [SHIFT_W-1:0] shift;
	logic               pe_in_valid;
	pe_operands_t       pe_in;

////////////////////////////////////////////////////////////////////////////
// control

	inst_ctrl u_inst_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.instruct   (instruct),
		.inst_empty (inst_empty),
		.inst_req   (inst_req),
		.load_start (load_start),
		.load_cmd   (load_cmd),
		.load_done  (load_done),
		.conv_start (conv_start),
		.conv_cmd   (conv_cmd),
		.conv_done  (conv_done)
	);

	ddr_reader u_ddr_reader (
		.clk                 (clk),
		.rst_n               (rst_n),
		.load_start          (load_start),
		.load_cmd            (load_cmd),
		.load_done           (load_done),
		.init_calib_complete (init_calib_complete),
		.app_rdy             (app_rdy),
		.app_rd_data_valid   (app_rd_data_valid),
		.app_rd_data         (app_rd_data),
		.app_cmd             (app_cmd),
		.app_addr            (app_addr),
		.app_en              (app_en),
		.buf_wr              (buf_wr)
	);

	conv_seq u_conv_seq (
		.clk          (clk),
		.rst_n        (rst_n),
		.conv_start   (conv_start),
		.conv_cmd     (conv_cmd),
		.rd_en        (rd_en),
		.rd           (rd),
		.shift        (shift),
		.result_valid (result_valid),  // counted back for done
		.conv_done    (conv_done)
	);

////////////////////////////////////////////////////////////////////////////
// buffers and datapath

	local_buffers u_local_buffers (
		.clk         (clk),
		.buf_wr      (buf_wr),
		.rd_en       (rd_en),
		.rd          (rd),
		.shift       (shift),
		.pe_in_valid (pe_in_valid),
		.pe_in       (pe_in)
	);

	pe_core u_pe_core (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (pe_in_valid),
		.pe_in        (pe_in),
		.result_valid (result_valid),
		.result       (result)
	);

endmodule

//--- tb_hwcnn.sv
module tb_hwcnn import hwcnn_pkg::*; ();

	localparam int NROWS     = 12;
	localparam int MEM_DEPTH = 512;
	localparam int TIMEOUT   = 5000;  // cycles allowed for the whole table

	logic                  clk;
	logic                  rst_n;
	logic [INST_W-1:0]     instruct;
	logic                  inst_empty;
	logic                  inst_req;
	logic                  init_calib_complete;
	logic                  app_rdy;
	logic                  app_rd_data_valid;
	logic [BEAT_W-1:0]     app_rd_data;
	logic [CMD_W-1:0]      app_cmd;
	logic [DDR_ADDR_W-1:0] app_addr;
	logic                  app_en;
	logic                  result_valid;
	logic [ACC_W-1:0]      result;

	int                    seed = 16;
	logic [BEAT_W-1:0]     mem     [MEM_DEPTH];           // ddr contents
	logic [BEAT_W-1:0]     ref_buf [NUM_TGT][BUF_DEPTH];  // reference copy of the buffers
	logic [INST_W-1:0]     rows    [NROWS];
	logic [INST_W-1:0]     fifo_q  [$];
	logic [DDR_ADDR_W-1:0] addr_q  [$];                   // expected read addresses
	logic [ACC_W-1:0]      exp_q   [$];                   // expected results in order
	logic [BEAT_W-1:0]     ret_data [$];
	int                    ret_due  [$];
	int                    fifo_rd;
	int                    cyc;
	int                    due;
	int                    last_due;
	int                    res_cnt;
	int                    exp_total;

	hwcnn_top DUT (
		.clk                 (clk),
		.rst_n               (rst_n),
		.instruct            (instruct),
		.inst_empty          (inst_empty),
		.inst_req            (inst_req),
		.init_calib_complete (init_calib_complete),
		.app_rdy             (app_rdy),
		.app_rd_data_valid   (app_rd_data_valid),
		.app_rd_data         (app_rd_data),
		.app_cmd             (app_cmd),
		.app_addr            (app_addr),
		.app_en              (app_en),
		.result_valid        (result_valid),
		.result              (result)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

////////////////////////////////////////////////////////////////////////////
// helpers

	task automatic abort_run();
		$display("Done: errors found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_equal(input logic [BEAT_W-1:0] got, input logic [BEAT_W-1:0] exp,
			input string what);
		if (got !== exp) begin
			$display("Fail at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
			abort_run();
		end
	endtask

	function automatic logic [INST_W-1:0] load_row(target_e t, int ddr, int ba, int beats);
		inst_t it;
		it = '0;
		it.opcode                    = OP_LOAD;
		it.payload.load.cmd.target   = t;
		it.payload.load.cmd.ddr_addr = DDR_ADDR_W'(ddr);
		it.payload.load.cmd.buf_addr = BUF_ADDR_W'(ba);
		it.payload.load.cmd.beats    = CNT_W'(beats);
		return it;
	endfunction

	function automatic logic [INST_W-1:0] conv_row(int w, int b, int f, int count, int sh);
		inst_t it;
		it = '0;
		it.opcode                       = OP_CONV;
		it.payload.conv.cmd.weight_addr = BUF_ADDR_W'(w);
		it.payload.conv.cmd.bias_addr   = BUF_ADDR_W'(b);
		it.payload.conv.cmd.feat_addr   = BUF_ADDR_W'(f);
		it.payload.conv.cmd.count       = CNT_W'(count);
		it.payload.conv.cmd.shift       = SHIFT_W'(sh);
		return it;
	endfunction

	// dot product of nine signed lanes plus bias, then arithmetic shift
	function automatic logic [ACC_W-1:0] conv_ref(logic [BEAT_W-1:0] w, logic [BEAT_W-1:0] f,
			logic [BEAT_W-1:0] b, int sh);
		longint acc;
		int     wv;
		int     fv;
		acc = $signed(b[BIAS_W-1:0]);
		for (int i = 0; i < LANES; i++) begin
			wv  = $signed(w[i*VAL_W +: VAL_W]);
			fv  = $signed(f[i*VAL_W +: VAL_W]);
			acc = acc + wv * fv;
		end
		acc = acc >>> sh;
		return acc[ACC_W-1:0];
	endfunction

////////////////////////////////////////////////////////////////////////////
// instruction fifo and memory controller models

	always @(posedge clk) begin
		if (!rst_n) begin
			inst_empty <= 1'b1;
		end else begin
			if (inst_req) begin
				instruct <= fifo_q[fifo_rd];  // valid the cycle after the pop
				fifo_rd = fifo_rd + 1;
			end
			inst_empty <= (fifo_rd >= NROWS) || ($unsigned($random(seed)) % 4 == 0);
		end
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			app_rdy           <= 1'b0;
			app_rd_data_valid <= 1'b0;
		end else begin
			cyc = cyc + 1;
			if (!init_calib_complete)
				check_equal(app_en, 1'b0, "app_en during calibration");
			if (app_en && app_rdy) begin
				if (addr_q.size() == 0) begin
					$display("read command accepted with no load beat left to fetch");
					abort_run();
				end else begin
					check_equal(app_addr, addr_q.pop_front(), "read address");
					check_equal(app_cmd, CMD_READ, "read command code");
					due = cyc + 1 + $unsigned($random(seed)) % 6;
					if (due <= last_due)
						due = last_due + 1;  // returns stay in order
					last_due = due;
					ret_due.push_back(due);
					ret_data.push_back(mem[app_addr]);
				end
			end
			app_rdy <= ($unsigned($random(seed)) % 3) != 0;
			if (ret_due.size() > 0 && ret_due[0] <= cyc) begin
				void'(ret_due.pop_front());
				app_rd_data_valid <= 1'b1;
				app_rd_data       <= ret_data.pop_front();
			end else begin
				app_rd_data_valid <= 1'b0;
			end
		end
	end

	// result monitor
	always @(posedge clk) begin
		if (rst_n && result_valid) begin
			if (exp_q.size() == 0) begin
				$display("result appeared with no convolution window left to expect");
				abort_run();
			end else begin
				check_equal(result, exp_q.pop_front(), "convolution result");
				res_cnt = res_cnt + 1;
			end
		end
	end

////////////////////////////////////////////////////////////////////////////
// main sequence

	initial begin
		logic [95:0] rnd;
		inst_t       it;
		load_cmd_t   lc;
		conv_cmd_t   cc;
		int          waited;

		rst_n               = 1'b0;
		instruct            = '0;
		inst_empty          = 1'b1;
		init_calib_complete = 1'b0;
		app_rdy             = 1'b0;
		app_rd_data_valid   = 1'b0;
		app_rd_data         = '0;
		fifo_rd             = 0;
		cyc                 = 0;
		last_due            = 0;
		res_cnt             = 0;
		exp_total           = 0;

		for (int i = 0; i < MEM_DEPTH; i++) begin
			rnd    = {$random(seed), $random(seed), $random(seed)};
			mem[i] = rnd[BEAT_W-1:0];
		end
		mem[300] = {{(BEAT_W-BIAS_W){1'b0}}, 20'h9C400};  // large negative bias
		mem[301] = {LANES{8'h80}};                         // kernel of -128

		rows[0]  = load_row(TGT_WEIGHT, 16, 0, 4);
		rows[1]  = '0;                                     // nop
		rows[2]  = load_row(TGT_BIAS, 100, 0, 3);
		rows[3]  = load_row(TGT_FEATURE, 400, 10, 24);
		rows[4]  = conv_row(0, 0, 10, 8, 0);
		rows[5]  = load_row(TGT_WEIGHT, 301, 4, 1);
		rows[6]  = load_row(TGT_BIAS, 300, 3, 1);
		rows[7]  = '0;
		rows[8]  = conv_row(4, 3, 12, 6, 3);
		rows[9]  = conv_row(2, 1, 20, 10, 7);              // back to back, same buffers
		rows[10] = conv_row(1, 2, 10, 24, 9);
		rows[11] = '0;

		// queue each row and work out what it should produce
		for (int r = 0; r < NROWS; r++) begin
			it = inst_t'(rows[r]);
			fifo_q.push_back(rows[r]);
			if (it.opcode == OP_LOAD) begin
				lc = it.payload.load.cmd;
				for (int k = 0; k < lc.beats; k++) begin
					ref_buf[int'(lc.target)][lc.buf_addr + k] = mem[lc.ddr_addr + k];
					addr_q.push_back(lc.ddr_addr + k);
				end
			end else if (it.opcode == OP_CONV) begin
				cc = it.payload.conv.cmd;
				for (int k = 0; k < cc.count; k++) begin
					exp_q.push_back(conv_ref(ref_buf[TGT_WEIGHT][cc.weight_addr],
						ref_buf[TGT_FEATURE][cc.feat_addr + k],
						ref_buf[TGT_BIAS][cc.bias_addr], cc.shift));
				end
				exp_total = exp_total + cc.count;
			end
		end

		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_equal(inst_req, 1'b0, "inst_req after reset");
		check_equal(app_en, 1'b0, "app_en after reset");
		check_equal(result_valid, 1'b0, "result_valid after reset");

		repeat (20) @(posedge clk);  // memory still calibrating
		init_calib_complete <= 1'b1;

		waited = 0;
		while (res_cnt < exp_total && waited < TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (res_cnt < exp_total) begin
			$display("timed out after %0d cycles with %0d of %0d results", waited, res_cnt,
				exp_total);
			abort_run();
		end else begin
			repeat (30) @(negedge clk);  // let stray results or fetches show up
			check_equal(addr_q.size(), 0, "read addresses never issued");
			check_equal(fifo_rd, NROWS, "instructions fetched");
			$display("Done: no errors");
			$finish;
		end
	end

endmodule

//--- flist.f
hwcnn_pkg.sv
inst_ctrl.sv
ddr_reader.sv
local_buffers.sv
conv_seq.sv
pe_core.sv
hwcnn_top.sv
tb_hwcnn.sv
